/* src/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	typedef logic [4:0]  regIdx_t;	// gpr index
	typedef logic [31:0] word_t;

	// ------------------------------------------------------------------
	// instruction formats, both views of the same 32-bit word
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] opcode;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	typedef struct packed {
		logic [5:0]  opcode;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm;	// offset or literal
	} iType_t;

	// j target lives in bits 25:0 of either view
	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_u;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;	// r-type, see funct
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// special funct codes
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	localparam word_t RESET_PC = 32'h0000_0000;	// boot vector

endpackage

`default_nettype wire

/* src/pipeCtrlPkg.sv */
`default_nettype none

package pipeCtrlPkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,	// signed compare
		ALU_SLL,
		ALU_LUI	// b into upper half
	} aluOp_e;

	// operand source for the forwarding muxes
	typedef enum logic [1:0] {
		FWD_REG,	// value read in decode
		FWD_WB,
		FWD_MEM
	} fwdSel_e;

	// matches opcode bits 1:0 of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD = 2'b11
	} memSize_e;

	// ------------------------------------------------------------------
	// stage controls and pipeline registers
	// ------------------------------------------------------------------
	typedef struct packed {
		logic     regWrite;
		logic     memToReg;	// wb takes load data
		logic     memWrite;
		logic     memRead;
		logic     aluSrcImm;	// b operand is the immediate
		aluOp_e   aluOp;
		memSize_e memSize;
		logic     memUnsigned;	// zero-extend loads
		logic     useShamt;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '0;	// no writes anywhere

	typedef struct packed {
		ctrl_t               ctrl;
		mipsIsaPkg::regIdx_t rs;
		mipsIsaPkg::regIdx_t rt;
		mipsIsaPkg::regIdx_t dest;
		logic [4:0]          shamt;
		mipsIsaPkg::word_t   opA;
		mipsIsaPkg::word_t   opB;	// rt value, also store data
		mipsIsaPkg::word_t   imm;
	} idEx_t;

	typedef struct packed {
		ctrl_t               ctrl;
		mipsIsaPkg::regIdx_t dest;
		mipsIsaPkg::word_t   aluOut;	// result or byte address
		mipsIsaPkg::word_t   storeData;
	} exMem_t;

	typedef struct packed {
		logic                regWrite;
		logic                memToReg;
		mipsIsaPkg::regIdx_t dest;
		mipsIsaPkg::word_t   aluOut;
		mipsIsaPkg::word_t   loadData;
	} memWb_t;

endpackage

`default_nettype wire

/* src/instrDecoder.sv */
`default_nettype none

module instrDecoder (
	input  wire mipsIsaPkg::instr_u instr_i,
	output pipeCtrlPkg::ctrl_t      ctrl_o,
	output mipsIsaPkg::regIdx_t     dest_o,
	output mipsIsaPkg::word_t       imm_o,
	output logic                    isBranch_o,
	output logic                    isJump_o,
	output logic                    branchNe_o
);
	import mipsIsaPkg::*;
	import pipeCtrlPkg::*;

	memSize_e accSize;	// width from opcode low bits

	always_comb begin
		case (instr_i.i.opcode[1:0])
			2'b00:   accSize = MEM_BYTE;
			2'b01:   accSize = MEM_HALF;
			default: accSize = MEM_WORD;
		endcase
	end

	always_comb begin
		ctrl_o     = CTRL_NOP;
		dest_o     = instr_i.i.rt;	// i-type writes rt
		imm_o      = {{16{instr_i.i.imm[15]}}, instr_i.i.imm};
		isBranch_o = 1'b0;
		isJump_o   = 1'b0;
		branchNe_o = 1'b0;
		case (instr_i.i.opcode)
			OP_SPECIAL: begin
				dest_o          = instr_i.r.rd;
				ctrl_o.regWrite = 1'b1;
				case (instr_i.r.funct)
					FN_SLL: begin
						ctrl_o.aluOp    = ALU_SLL;
						ctrl_o.useShamt = 1'b1;
					end
					FN_ADDU: ctrl_o.aluOp = ALU_ADD;
					FN_SUBU: ctrl_o.aluOp = ALU_SUB;
					FN_AND:  ctrl_o.aluOp = ALU_AND;
					FN_OR:   ctrl_o.aluOp = ALU_OR;
					FN_SLT:  ctrl_o.aluOp = ALU_SLT;
					default: ctrl_o.regWrite = 1'b0;	// unsupported funct
				endcase
			end
			OP_ADDIU: begin
				ctrl_o.regWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
			end
			OP_ORI, OP_LUI: begin
				imm_o            = {16'h0000, instr_i.i.imm};	// logical, zero-extend
				ctrl_o.regWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.aluOp     = (instr_i.i.opcode == OP_ORI) ? ALU_OR : ALU_LUI;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				ctrl_o.regWrite    = 1'b1;
				ctrl_o.memToReg    = 1'b1;
				ctrl_o.memRead     = 1'b1;
				ctrl_o.aluSrcImm   = 1'b1;	// base + offset
				ctrl_o.memSize     = accSize;
				ctrl_o.memUnsigned = instr_i.i.opcode[2];	// lbu, lhu
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl_o.memWrite  = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.memSize   = accSize;
			end
			OP_BEQ, OP_BNE: begin
				isBranch_o = 1'b1;
				branchNe_o = instr_i.i.opcode[0];
			end
			OP_J:    isJump_o = 1'b1;
			default: ;	// unknown op runs as a nop
		endcase
	end

endmodule

`default_nettype wire

/* src/regFile.sv */
`default_nettype none

module regFile (
	input  wire                      clka,
	input  wire                      rstN_i,
	input  wire                      we_i,
	input  wire mipsIsaPkg::regIdx_t wa_i,
	input  wire mipsIsaPkg::word_t   wd_i,
	input  wire mipsIsaPkg::regIdx_t ra1_i,
	input  wire mipsIsaPkg::regIdx_t ra2_i,
	output mipsIsaPkg::word_t        rd1_o,
	output mipsIsaPkg::word_t        rd2_o
);
	import mipsIsaPkg::*;

	word_t regs [32];

	always_ff @(posedge clka or negedge rstN_i) begin
		if (!rstN_i)
			regs <= '{default: '0};	// programs start from zeroed gprs
		else if (we_i && wa_i != '0)
			regs[wa_i] <= wd_i;
	end

	// r0 reads zero, same-cycle write passes straight through
	assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
	assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

	// writeback aimed at r0 must leave it untouched
	r0Fixed: assert property (@(posedge clka) disable iff (!rstN_i)
		(we_i && wa_i == '0) |=> (regs[0] == '0) && $stable(regs[0]));

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`default_nettype none

module hazardUnit (
	input  wire                      clka,
	input  wire                      rstN_i,
	input  wire mipsIsaPkg::regIdx_t rsD_i,
	input  wire mipsIsaPkg::regIdx_t rtD_i,
	input  wire                      isBranchD_i,
	input  wire mipsIsaPkg::regIdx_t rsE_i,
	input  wire mipsIsaPkg::regIdx_t rtE_i,
	input  wire pipeCtrlPkg::ctrl_t  ctrlE_i,
	input  wire mipsIsaPkg::regIdx_t destE_i,
	input  wire pipeCtrlPkg::ctrl_t  ctrlM_i,
	input  wire mipsIsaPkg::regIdx_t destM_i,
	input  wire                      regWriteW_i,
	input  wire mipsIsaPkg::regIdx_t destW_i,
	output pipeCtrlPkg::fwdSel_e     fwdAE_o,
	output pipeCtrlPkg::fwdSel_e     fwdBE_o,
	output pipeCtrlPkg::fwdSel_e     fwdAD_o,
	output pipeCtrlPkg::fwdSel_e     fwdBD_o,
	output logic                     stallFD_o
);
	import mipsIsaPkg::*;
	import pipeCtrlPkg::*;

	logic loadUse, branchWait;

	// producer writes a real register that the consumer names
	function automatic logic hits(logic we, regIdx_t dest, regIdx_t src);
		return we && dest != '0 && dest == src;
	endfunction

	// ------------------------------------------------------------------
	// forwarding, mem stage is younger so it wins
	// ------------------------------------------------------------------
	assign fwdAE_o = hits(ctrlM_i.regWrite, destM_i, rsE_i) ? FWD_MEM :
		hits(regWriteW_i, destW_i, rsE_i) ? FWD_WB : FWD_REG;
	assign fwdBE_o = hits(ctrlM_i.regWrite, destM_i, rtE_i) ? FWD_MEM :
		hits(regWriteW_i, destW_i, rtE_i) ? FWD_WB : FWD_REG;

	// decode only needs mem, wb goes through the regfile bypass
	assign fwdAD_o = hits(ctrlM_i.regWrite, destM_i, rsD_i) ? FWD_MEM : FWD_REG;
	assign fwdBD_o = hits(ctrlM_i.regWrite, destM_i, rtD_i) ? FWD_MEM : FWD_REG;

	// ------------------------------------------------------------------
	// stalls
	// ------------------------------------------------------------------
	assign loadUse = hits(ctrlE_i.memRead, destE_i, rsD_i) ||
		hits(ctrlE_i.memRead, destE_i, rtD_i);	// data not back until wb

	// compare in decode can't see execute, nor a load still in mem
	assign branchWait = isBranchD_i && (
		hits(ctrlE_i.regWrite, destE_i, rsD_i) || hits(ctrlE_i.regWrite, destE_i, rtD_i) ||
		hits(ctrlM_i.memRead, destM_i, rsD_i) || hits(ctrlM_i.memRead, destM_i, rtD_i));

	assign stallFD_o = loadUse || branchWait;

	// a held branch stays in decode, so its redirect waits for a free cycle
	stallHoldsBranch: assert property (@(posedge clka) disable iff (!rstN_i)
		(isBranchD_i && stallFD_o) |=> isBranchD_i);

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`default_nettype none

module aluUnit (
	input  wire pipeCtrlPkg::aluOp_e op_i,
	input  wire mipsIsaPkg::word_t   a_i,
	input  wire mipsIsaPkg::word_t   b_i,
	input  wire logic [4:0]          shamt_i,
	output mipsIsaPkg::word_t        y_o
);
	import mipsIsaPkg::*;
	import pipeCtrlPkg::*;

	word_t diff;

	assign diff = a_i - b_i;	// shared by sub and slt

	always_comb begin
		case (op_i)
			ALU_ADD: y_o = a_i + b_i;
			ALU_SUB: y_o = diff;
			ALU_AND: y_o = a_i & b_i;
			ALU_OR:  y_o = a_i | b_i;
			// signed less-than, sign bits differ means no overflow trick needed
			ALU_SLT: y_o = {31'b0, (a_i[31] != b_i[31]) ? a_i[31] : diff[31]};
			ALU_SLL: y_o = b_i << shamt_i;	// rt shifted by sa
			ALU_LUI: y_o = {b_i[15:0], 16'h0000};
			default: y_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/memAccess.sv */
`default_nettype none

module memAccess (
	input  wire                     clka,
	input  wire                     rstN_i,
	input  wire pipeCtrlPkg::ctrl_t ctrl_i,
	input  wire mipsIsaPkg::word_t  addr_i,
	input  wire mipsIsaPkg::word_t  storeData_i,
	input  wire mipsIsaPkg::word_t  dmemRdata_i,
	output mipsIsaPkg::word_t       wdata_o,
	output logic [3:0]              mask_o,
	output mipsIsaPkg::word_t       loadData_o
);
	import mipsIsaPkg::*;
	import pipeCtrlPkg::*;

	logic [4:0] laneShift;	// byte offset in bits
	word_t      laneWord;	// addressed lane moved to bit 0

	assign laneShift = {addr_i[1:0], 3'b000};
	assign laneWord  = dmemRdata_i >> laneShift;

	// ------------------------------------------------------------------
	// store side
	// ------------------------------------------------------------------
	always_comb begin
		wdata_o = storeData_i << laneShift;	// low bytes into their lane
		case (ctrl_i.memSize)
			MEM_BYTE: mask_o = 4'b0001 << addr_i[1:0];
			MEM_HALF: mask_o = 4'b0011 << addr_i[1:0];
			default: begin
				wdata_o = storeData_i;
				mask_o  = 4'b1111;
			end
		endcase
		if (!ctrl_i.memWrite)
			mask_o = 4'b0000;	// no strobe outside stores
	end

	// ------------------------------------------------------------------
	// load side
	// ------------------------------------------------------------------
	always_comb begin
		case (ctrl_i.memSize)
			MEM_BYTE: loadData_o = ctrl_i.memUnsigned ? {24'h0, laneWord[7:0]} :
				{{24{laneWord[7]}}, laneWord[7:0]};
			MEM_HALF: loadData_o = ctrl_i.memUnsigned ? {16'h0, laneWord[15:0]} :
				{{16{laneWord[15]}}, laneWord[15:0]};
			default:  loadData_o = dmemRdata_i;
		endcase
	end

	// program must keep halfword accesses aligned, nothing traps here
	halfAligned: assert property (@(posedge clka) disable iff (!rstN_i)
		((ctrl_i.memRead || ctrl_i.memWrite) && ctrl_i.memSize == MEM_HALF) |-> !addr_i[0]);

endmodule

`default_nettype wire

/* src/mipsPipeline.sv */
`default_nettype none

module mipsPipeline (
	input  wire                     clka,
	input  wire                     rstN_i,
	input  wire mipsIsaPkg::instr_u instr_i,
	input  wire mipsIsaPkg::word_t  dmemRdata_i,
	output mipsIsaPkg::word_t       imemAddr_o,
	output mipsIsaPkg::word_t       dmemAddr_o,
	output mipsIsaPkg::word_t       dmemWdata_o,
	output logic [3:0]              dmemMask_o
);
	import mipsIsaPkg::*;
	import pipeCtrlPkg::*;

	typedef struct packed {
		instr_u instr;
		word_t  pcPlus4;	// base for branch and jump targets
	} ifId_t;

	// ------------------------------------------------------------------
	// fetch
	// ------------------------------------------------------------------
	word_t pcQ, pcNext, pcPlus4F;
	ifId_t ifIdQ;
	logic  stallFD;

	assign pcPlus4F   = pcQ + 32'd4;
	assign imemAddr_o = pcQ;

	always_ff @(posedge clka or negedge rstN_i) begin
		if (!rstN_i) begin
			pcQ   <= RESET_PC;
			ifIdQ <= '0;	// all-zero word is sll r0 as a nop
		end else if (!stallFD) begin
			pcQ   <= pcNext;
			ifIdQ <= '{instr: instr_i, pcPlus4: pcPlus4F};
		end
	end

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------
	ctrl_t   ctrlD;
	regIdx_t destD;
	word_t   immD, rd1D, rd2D, opAD, opBD, resultW;
	logic    isBranchD, isJumpD, branchNeD, takeBranch;
	fwdSel_e fwdAE, fwdBE, fwdAD, fwdBD;
	idEx_t   idExQ;
	exMem_t  exMemQ;
	memWb_t  memWbQ;

	// one forwarding mux shape for decode and execute
	function automatic word_t fwdPick(fwdSel_e sel, word_t regVal, word_t wbVal, word_t memVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	instrDecoder uDec (
		.instr_i(ifIdQ.instr), .ctrl_o(ctrlD), .dest_o(destD), .imm_o(immD),
		.isBranch_o(isBranchD), .isJump_o(isJumpD), .branchNe_o(branchNeD)
	);

	regFile uRegs (
		.clka(clka), .rstN_i(rstN_i),
		.we_i(memWbQ.regWrite), .wa_i(memWbQ.dest), .wd_i(resultW),
		.ra1_i(ifIdQ.instr.r.rs), .ra2_i(ifIdQ.instr.r.rt),
		.rd1_o(rd1D), .rd2_o(rd2D)
	);

	assign opAD = fwdPick(fwdAD, rd1D, resultW, exMemQ.aluOut);	// branch compare only
	assign opBD = fwdPick(fwdBD, rd2D, resultW, exMemQ.aluOut);
	assign takeBranch = isBranchD && ((opAD == opBD) != branchNeD);

	// delay slot is already being fetched, so fd is never flushed
	always_comb begin
		if (isJumpD)
			pcNext = {ifIdQ.pcPlus4[31:28], ifIdQ.instr[25:0], 2'b00};
		else if (takeBranch)
			pcNext = ifIdQ.pcPlus4 + {immD[29:0], 2'b00};
		else
			pcNext = pcPlus4F;
	end

	hazardUnit uHaz (
		.clka(clka), .rstN_i(rstN_i),
		.rsD_i(ifIdQ.instr.r.rs), .rtD_i(ifIdQ.instr.r.rt), .isBranchD_i(isBranchD),
		.rsE_i(idExQ.rs), .rtE_i(idExQ.rt), .ctrlE_i(idExQ.ctrl), .destE_i(idExQ.dest),
		.ctrlM_i(exMemQ.ctrl), .destM_i(exMemQ.dest),
		.regWriteW_i(memWbQ.regWrite), .destW_i(memWbQ.dest),
		.fwdAE_o(fwdAE), .fwdBE_o(fwdBE), .fwdAD_o(fwdAD), .fwdBD_o(fwdBD),
		.stallFD_o(stallFD)
	);

	always_ff @(posedge clka or negedge rstN_i) begin
		if (!rstN_i)
			idExQ <= '0;
		else if (stallFD)
			idExQ <= '0;	// bubble while decode is held
		else
			idExQ <= '{ctrl: ctrlD, rs: ifIdQ.instr.r.rs, rt: ifIdQ.instr.r.rt, dest: destD,
				shamt: ctrlD.useShamt ? ifIdQ.instr.r.shamt : 5'd0,
				opA: rd1D, opB: rd2D, imm: immD};
	end

	// ------------------------------------------------------------------
	// execute
	// ------------------------------------------------------------------
	word_t srcAE, storeDataE, aluY;

	assign srcAE      = fwdPick(fwdAE, idExQ.opA, resultW, exMemQ.aluOut);
	assign storeDataE = fwdPick(fwdBE, idExQ.opB, resultW, exMemQ.aluOut);

	aluUnit uAlu (
		.op_i(idExQ.ctrl.aluOp), .a_i(srcAE),
		.b_i(idExQ.ctrl.aluSrcImm ? idExQ.imm : storeDataE),
		.shamt_i(idExQ.shamt), .y_o(aluY)
	);

	always_ff @(posedge clka or negedge rstN_i) begin
		if (!rstN_i)
			exMemQ <= '0;
		else
			exMemQ <= '{ctrl: idExQ.ctrl, dest: idExQ.dest, aluOut: aluY, storeData: storeDataE};
	end

	// ------------------------------------------------------------------
	// memory and writeback
	// ------------------------------------------------------------------
	word_t loadDataM;

	assign dmemAddr_o = {exMemQ.aluOut[31:2], 2'b00};	// lanes picked by the mask

	memAccess uMem (
		.clka(clka), .rstN_i(rstN_i),
		.ctrl_i(exMemQ.ctrl), .addr_i(exMemQ.aluOut), .storeData_i(exMemQ.storeData),
		.dmemRdata_i(dmemRdata_i),
		.wdata_o(dmemWdata_o), .mask_o(dmemMask_o), .loadData_o(loadDataM)
	);

	always_ff @(posedge clka or negedge rstN_i) begin
		if (!rstN_i)
			memWbQ <= '0;
		else
			memWbQ <= '{regWrite: exMemQ.ctrl.regWrite, memToReg: exMemQ.ctrl.memToReg,
				dest: exMemQ.dest, aluOut: exMemQ.aluOut, loadData: loadDataM};
	end

	assign resultW = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluOut;

endmodule

`default_nettype wire

/* test/tbIsaModel.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// ----------------------------------------------------------------------
// instruction encoders and program builders
// ----------------------------------------------------------------------
function automatic logic [31:0] rWord(logic [5:0] fn, int rs, int rt, int rd, int sa);
	return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
endfunction

function automatic logic [31:0] iWord(logic [5:0] op, int rs, int rt, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};	// imm truncated to 16 bits
endfunction

function automatic logic [31:0] jWord(int idx);
	return {OP_J, 26'(idx)};	// idx is a word index
endfunction

function automatic void emit(logic [31:0] w);
	rom[progLen] = w;
	progLen++;
endfunction

// byte strobe widened to a bit mask
function automatic logic [31:0] laneBits(logic [3:0] m);
	return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

// ram contents before each program, every address bit matters
function automatic logic [31:0] fillWord(int idx);
	logic [31:0] a;
	a = 32'(idx) << 2;
	return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
endfunction

// ----------------------------------------------------------------------
// sequential interpreter, fills the expected store log
// ----------------------------------------------------------------------
function automatic bit interpretProgram();
	logic [31:0] gpr [32];
	logic [31:0] mem [ROM_WORDS];
	logic [31:0] pc, npc, nnpc, w, a, b, sImm, ea, lane, res, sd;
	logic [4:0]  sh, dst;
	logic [3:0]  m;
	bit          wr;
	int          i;
	expAddr.delete();
	expData.delete();
	expMask.delete();
	for (i = 0; i < 32; i++)
		gpr[i] = '0;
	for (i = 0; i < ROM_WORDS; i++)
		mem[i] = fillWord(i);
	pc  = RESET_PC;
	npc = pc + 32'd4;
	for (i = 0; i < 20000; i++) begin
		w    = rom[pc[11:2]];
		a    = gpr[w[25:21]];
		b    = gpr[w[20:16]];
		sImm = {{16{w[15]}}, w[15:0]};
		ea   = a + sImm;	// effective address for loads and stores
		sh   = {ea[1:0], 3'b000};
		lane = mem[ea[11:2]] >> sh;
		nnpc = npc + 32'd4;	// sequential unless a branch or jump says otherwise
		dst  = w[20:16];
		wr   = 1'b1;
		m    = 4'b0000;
		res  = '0;
		case (w[31:26])
			OP_SPECIAL: begin
				dst = w[15:11];
				case (w[5:0])
					FN_SLL:  res = b << w[10:6];
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = ea;
			OP_ORI:   res = a | {16'h0000, w[15:0]};
			OP_LUI:   res = {w[15:0], 16'h0000};
			OP_LB:    res = {{24{lane[7]}}, lane[7:0]};
			OP_LBU:   res = {24'h0, lane[7:0]};
			OP_LH:    res = {{16{lane[15]}}, lane[15:0]};
			OP_LHU:   res = {16'h0, lane[15:0]};
			OP_LW:    res = mem[ea[11:2]];
			OP_SB, OP_SH, OP_SW: begin
				wr = 1'b0;
				m  = (w[27:26] == 2'b00) ? 4'b0001 << ea[1:0] :
					(w[27:26] == 2'b01) ? 4'b0011 << ea[1:0] : 4'b1111;
			end
			OP_BEQ: begin
				wr = 1'b0;
				if (a == b)
					nnpc = npc + {sImm[29:0], 2'b00};	// relative to the delay slot
			end
			OP_BNE: begin
				wr = 1'b0;
				if (a != b)
					nnpc = npc + {sImm[29:0], 2'b00};
			end
			OP_J: begin
				wr   = 1'b0;
				nnpc = {npc[31:28], w[25:0], 2'b00};
			end
			default: wr = 1'b0;
		endcase
		if (m != 4'b0000) begin
			sd = (b << sh) & laneBits(m);	// only the written lanes count
			expAddr.push_back({ea[31:2], 2'b00});
			expData.push_back(sd);
			expMask.push_back(m);
			mem[ea[11:2]] = (mem[ea[11:2]] & ~laneBits(m)) | sd;
			if ({ea[31:2], 2'b00} == END_ADDR)
				return 1'b1;
		end
		if (wr && dst != 5'd0)
			gpr[dst] = res;
		pc  = npc;
		npc = nnpc;
	end
	return 1'b0;	// ran away without reaching the end marker
endfunction

`endif

/* test/tbMipsPipeline.sv */
`default_nettype none

module tbMipsPipeline;
	import mipsIsaPkg::*;

	localparam int          ROM_WORDS = 1024;
	localparam logic [31:0] END_ADDR  = 32'h0000_0ffc;	// store here ends a program

	logic        clka, rstN;
	logic [31:0] instrWord, dmemRdata, imemAddr, dmemAddr, dmemWdata;
	logic [3:0]  dmemMask;

	logic [31:0] rom [ROM_WORDS];
	logic [31:0] ram [ROM_WORDS];
	int          progLen;
	int          outSlot;	// next dump address
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [3:0]  expMask [$];
	logic [31:0] gotAddr [$];
	logic [31:0] gotData [$];
	logic [3:0]  gotMask [$];
	bit          endSeen;

	mipsPipeline UUT (
		.clka(clka), .rstN_i(rstN), .instr_i(instrWord), .dmemRdata_i(dmemRdata),
		.imemAddr_o(imemAddr), .dmemAddr_o(dmemAddr), .dmemWdata_o(dmemWdata),
		.dmemMask_o(dmemMask)
	);

	// combinational memory ports
	assign instrWord = rom[imemAddr[11:2]];
	assign dmemRdata = ram[dmemAddr[11:2]];

	initial begin
		clka = 1'b0;
		forever #4 clka = ~clka;
	end

	// ----------------------------------------------------------------------
	// data ram and store log
	// ----------------------------------------------------------------------
	always @(posedge clka) begin : storeLog
		int k;
		if (!rstN) begin
			for (k = 0; k < ROM_WORDS; k++)
				ram[k] <= fillWord(k);	// fresh contents per program
			gotAddr.delete();
			gotData.delete();
			gotMask.delete();
			endSeen = 1'b0;
		end else if (dmemMask != 4'b0000) begin
			gotAddr.push_back(dmemAddr);
			gotData.push_back(dmemWdata & laneBits(dmemMask));
			gotMask.push_back(dmemMask);
			for (k = 0; k < 4; k++)
				if (dmemMask[k])
					ram[dmemAddr[11:2]][8*k +: 8] <= dmemWdata[8*k +: 8];
			if (dmemAddr == END_ADDR)
				endSeen = 1'b1;
		end
	end

	task automatic checkEq(logic [31:0] got, logic [31:0] exp, string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------------------------------------
	// program builders
	// ----------------------------------------------------------------------
	task automatic startProgram();
		int i;
		for (i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;	// zero word is a nop
		progLen = 0;
		outSlot = 'h400;
		emit(iWord(OP_SW, 0, 0, 'h1f0));	// first store sets the strobe timing
	endtask

	task automatic dumpReg(int r);
		emit(iWord(OP_SW, 0, r, outSlot));
		outSlot += 4;
	endtask

	task automatic endProgram();
		emit(iWord(OP_SW, 0, 0, END_ADDR));
		emit(jWord(progLen));	// spin here
		emit(32'h0);
	endtask

	task automatic aluProgram();
		int n, rd, rs, rt;
		startProgram();
		for (n = 1; n < 16; n++) begin
			emit(iWord(OP_LUI, 0, n, $urandom));
			emit(iWord(OP_ORI, n, n, $urandom));	// depends on the line above
		end
		for (n = 0; n < 80; n++) begin
			rd = $urandom % 16;	// small register set for many hazards
			rs = $urandom % 16;
			rt = $urandom % 16;
			case ($urandom % 9)
				0: emit(rWord(FN_ADDU, rs, rt, rd, 0));
				1: emit(rWord(FN_SUBU, rs, rt, rd, 0));
				2: emit(rWord(FN_AND, rs, rt, rd, 0));
				3: emit(rWord(FN_OR, rs, rt, rd, 0));
				4: emit(rWord(FN_SLT, rs, rt, rd, 0));
				5: emit(rWord(FN_SLL, 0, rt, rd, $urandom % 32));
				6: emit(iWord(OP_ADDIU, rs, rd, $urandom));
				7: emit(iWord(OP_ORI, rs, rd, $urandom));
				default: emit(iWord(OP_LUI, 0, rd, $urandom));
			endcase
		end
		for (n = 1; n < 16; n++)
			dumpReg(n);
		endProgram();
	endtask

	task automatic memoryProgram();
		int off;
		startProgram();
		emit(iWord(OP_ADDIU, 0, 20, 'h300));	// prefilled load area
		emit(iWord(OP_ADDIU, 0, 21, 'h700));	// store area
		for (off = 0; off < 4; off++) begin
			emit(iWord(OP_LB, 20, 1, off));
			dumpReg(1);	// load-use stall
			emit(iWord(OP_LBU, 20, 2, off));
			dumpReg(2);
			emit(iWord(OP_SB, 21, 1, off));
		end
		for (off = 0; off < 4; off += 2) begin
			emit(iWord(OP_LH, 20, 3, 4 + off));
			dumpReg(3);
			emit(iWord(OP_LHU, 20, 4, 4 + off));
			dumpReg(4);
			emit(iWord(OP_SH, 21, 3, 8 + off));
		end
		emit(iWord(OP_LW, 20, 6, 8));
		emit(rWord(FN_ADDU, 6, 6, 7, 0));	// alu use right after the load
		dumpReg(7);
		emit(iWord(OP_LW, 21, 8, 0));	// read back the byte stores
		dumpReg(8);
		emit(iWord(OP_LBU, 21, 9, 9));
		dumpReg(9);
		emit(iWord(OP_LH, 21, 10, 10));
		dumpReg(10);
		endProgram();
	endtask

	task automatic branchProgram();
		startProgram();
		emit(iWord(OP_ADDIU, 0, 1, 5));
		emit(iWord(OP_BNE, 1, 0, 2));	// taken with r1 still in execute
		dumpReg(1);	// delay slot
		dumpReg(1);	// skipped
		emit(iWord(OP_ADDIU, 0, 2, 5));
		emit(iWord(OP_BEQ, 1, 2, 2));	// taken
		dumpReg(2);
		dumpReg(2);
		emit(iWord(OP_ADDIU, 0, 3, 7));
		emit(iWord(OP_BEQ, 3, 1, 2));	// not taken
		dumpReg(3);
		dumpReg(3);
		emit(iWord(OP_BNE, 1, 2, 2));	// equal operands so not taken
		dumpReg(1);
		dumpReg(2);
		// r11 holds the word stored at 0x300
		emit(iWord(OP_LUI, 0, 11, fillWord('h300 >> 2) >> 16));
		emit(iWord(OP_ORI, 11, 11, fillWord('h300 >> 2)));
		emit(iWord(OP_LW, 0, 4, 'h300));
		emit(iWord(OP_BEQ, 4, 11, 2));	// load in execute and then in mem
		dumpReg(4);
		dumpReg(4);
		emit(iWord(OP_LW, 0, 5, 'h300));
		emit(iWord(OP_ADDIU, 0, 6, 1));
		emit(iWord(OP_BNE, 5, 11, 2));	// load sits in mem
		dumpReg(5);
		dumpReg(6);	// runs only when the loaded value matches
		emit(iWord(OP_ADDIU, 0, 7, 3));
		emit(iWord(OP_ADDIU, 7, 7, -1));	// loop head
		emit(iWord(OP_BNE, 7, 0, -2));	// back to the head
		dumpReg(7);	// delay slot runs once per pass
		endProgram();
	endtask

	task automatic jumpProgram();
		startProgram();
		emit(iWord(OP_ADDIU, 0, 1, 'h11));
		emit(jWord(progLen + 4));	// over three words
		dumpReg(1);	// delay slot still stores
		emit(iWord(OP_ADDIU, 0, 1, 'h22));
		dumpReg(1);
		dumpReg(1);	// landing
		emit(jWord(progLen + 2));	// lands right after its delay slot
		emit(iWord(OP_ADDIU, 1, 1, 1));
		dumpReg(1);
		endProgram();
	endtask

	// ----------------------------------------------------------------------
	// reset, run one program, compare the logs
	// ----------------------------------------------------------------------
	task automatic holdReset();
		@(negedge clka);
		rstN = 1'b0;
	endtask

	task automatic runProgram(string name);
		int i;
		checkEq(32'(interpretProgram()), 32'd1, {name, " model reached end marker"});
		for (i = 0; i < 8; i++) begin
			@(negedge clka);
			checkEq(imemAddr, RESET_PC, {name, " pc in reset"});
			checkEq(32'(dmemMask), 32'h0, {name, " strobe in reset"});
		end
		rstN = 1'b1;
		for (i = 0; i < 3; i++) begin
			checkEq(32'(dmemMask), 32'h0, {name, " strobe before first store"});
			@(negedge clka);
		end
		checkEq(32'(dmemMask), 32'hf, {name, " first store three cycles in"});
		for (i = 0; i < 5000 && !endSeen; i++)
			@(negedge clka);
		if (!endSeen) begin
			$display("timeout: program %s never stored to the end marker", name);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
		checkEq(gotAddr.size(), expAddr.size(), {name, " store count"});
		for (i = 0; i < expAddr.size(); i++) begin
			checkEq(gotAddr[i], expAddr[i], $sformatf("%s store %0d addr", name, i));
			checkEq(gotData[i], expData[i], $sformatf("%s store %0d data", name, i));
			checkEq(32'(gotMask[i]), 32'(expMask[i]), $sformatf("%s store %0d mask", name, i));
		end
	endtask

	initial begin
		int i;
		void'($urandom(32'h6a67));
		rstN = 1'b0;
		for (i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		progLen = 0;
		outSlot = 'h400;
		holdReset();
		aluProgram();
		runProgram("alu");
		holdReset();
		memoryProgram();
		runProgram("memory");
		holdReset();
		branchProgram();
		runProgram("branch");
		holdReset();
		jumpProgram();
		runProgram("jump");
		$display("** PASS **");
		$finish;
	end

	`include "tbIsaModel.svh"

endmodule

`default_nettype wire

/* mipsPipeline.f */
+incdir+test
src/mipsIsaPkg.sv
src/pipeCtrlPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/aluUnit.sv
src/memAccess.sv
src/mipsPipeline.sv
test/tbMipsPipeline.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbMipsPipeline -f mipsPipeline.f -o simMips
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/simMips)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '\*\* PASS \*\*'; then
	exit 0
fi
exit 1
